//--- sources.f
rtl/jtag_pkg.sv
rtl/display_pkg.sv
rtl/jtag_capture.sv
rtl/display_buffer.sv
rtl/hex_renderer.sv
rtl/oled_spi.sv
rtl/jtag_scope_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_jtag_scope.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := sources.f
TOP        := tb_jtag_scope
RTL_TOP    := jtag_scope_top
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test passed
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
SOURCES    := $(shell cat $(FILELIST))
RTL_FILES  := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_jtag_scope.sv
`timescale 1ns/1ps

module tb_jtag_scope;
    import jtag_pkg::*;
    import display_pkg::*;

    localparam int     jtck_half       = 5;   // clk cycles per jtck phase
    localparam int     update_cycles   = 6;   // jupdate pulse width
    localparam int     frames_per_step = 3;   // clean frames between captures
    localparam int     step_count      = 8;   // waits for clean frames over the run
    localparam longint frame_ns        = 512 * 24 * 10;  // 512 bytes, 24 clk worst case
    localparam longint watchdog_ns     = (step_count + 2) * frames_per_step * frame_ns
                                         + 1_000_000;

    logic clk;
    logic arst_n;
    logic jtck;
    logic jtdi;
    logic jupdate;
    logic oled_csn;
    logic oled_clk;
    logic oled_mosi;
    logic oled_dc;
    logic oled_resn;
    int   test_step;
    int   frames_checked;
    int   data_bytes;
    int   value_errors;
    int   other_errors;

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    jtag_scope_top jtag_scope_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .jtck      (jtck),
        .jtdi      (jtdi),
        .jupdate   (jupdate),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    tb_checker checker_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .jtck           (jtck),
        .jtdi           (jtdi),
        .jupdate        (jupdate),
        .oled_csn       (oled_csn),
        .oled_clk       (oled_clk),
        .oled_mosi      (oled_mosi),
        .oled_dc        (oled_dc),
        .oled_resn      (oled_resn),
        .test_step      (test_step),
        .frames_checked (frames_checked),
        .data_bytes     (data_bytes),
        .value_errors   (value_errors),
        .other_errors   (other_errors)
    );

    // one random tdi bit per jtck period, tdi moves while jtck is low
    task automatic shift_bits(input int count);
        for (int i = 0; i < count; i++) begin
            jtdi <= 1'($urandom());
            repeat (jtck_half) @(posedge clk);
            jtck <= 1'b1;
            repeat (jtck_half) @(posedge clk);
            jtck <= 1'b0;
        end
    endtask

    task automatic pulse_update();
        jupdate <= 1'b1;
        repeat (update_cycles) @(posedge clk);
        jupdate <= 1'b0;
        repeat (jtck_half) @(posedge clk);  // idle tck phase after update
    endtask

    task automatic wait_clean_frames(input int count);
        int target;
        target = frames_checked + count;
        while (frames_checked < target) @(posedge clk);
    endtask

    // last pixel byte of a page is out, the next fetch is a few cycles away
    task automatic wait_page_end();
        int start;
        start = data_bytes;
        while (data_bytes == start || (data_bytes % column_count) != 0) @(posedge clk);
    endtask

    task automatic capture_row(input int bits);
        shift_bits(bits);
        pulse_update();
        wait_clean_frames(frames_per_step);
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d other, %0d frames compared",
                 value_errors, other_errors, frames_checked);
    endtask

    initial begin
        void'($urandom(32'h7a35_846e));
        jtck      = 1'b0;
        jtdi      = 1'b0;
        jupdate   = 1'b0;
        test_step = 0;
        @(posedge arst_n);
        while (data_bytes == 0) @(posedge clk);  // init bytes go out first
        test_step <= 1;  // all-zero rows
        wait_clean_frames(frames_per_step);
        test_step <= 2;
        capture_row(capture_bits);
        test_step <= 3;  // rows 1..3, then row 0 overwritten
        repeat (row_count) begin
            capture_row(capture_bits);
        end
        test_step <= 4;
        capture_row(20);  // older bits move up by 20
        // two updates two tck periods apart, the first one against a page fetch
        test_step <= 5;
        shift_bits(capture_bits);
        wait_page_end();
        pulse_update();
        shift_bits(2);
        pulse_update();
        wait_clean_frames(frames_per_step);
        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // stalled stream or lost frames end here
    initial begin
        #(watchdog_ns);
        $display("ERROR: timeout after %0d ns, frames stopped arriving on the oled pins",
                 watchdog_ns);
        print_counts();
        $display("Test failed");
        $finish;
    end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic clk,
    input  logic arst_n,
    input  logic jtck,
    input  logic jtdi,
    input  logic jupdate,
    input  logic oled_csn,
    input  logic oled_clk,
    input  logic oled_mosi,
    input  logic oled_dc,
    input  logic oled_resn,
    input  int   test_step,       // behavior the stimulus is working on
    output int   frames_checked,
    output int   data_bytes,      // pixel bytes seen since reset
    output int   value_errors,
    output int   other_errors
);
    import jtag_pkg::*;
    import display_pkg::*;

    localparam int frame_bytes   = page_count * column_count;
    localparam int settle_cycles = 100;  // quiet time needed before a compared frame

    typedef logic [7:0] frame_t [frame_bytes];

    longint                   cycle = 0;
    longint                   last_update = -1000;  // cycle of the latest jupdate edge
    longint                   frame_start;
    logic                     rst_q = 1'b0;
    logic                     rst_qq = 1'b0;
    int                       pin_errors = 0;
    int                       stream_errors;
    logic [capture_bits-1:0]  model_shift = '0;
    logic [capture_bits-1:0]  model_rows [row_count] = '{default: '0};
    logic [row_addr_bits-1:0] model_row = '0;
    logic [7:0]               shift_in;
    int                       bit_count;
    int                       init_seen;
    frame_t                   frame_buf;

    assign other_errors = pin_errors + stream_errors;

    function automatic string step_name(input int step);
        case (step)
            1: return "blank_frames";
            2: return "single_capture";
            3: return "row_wrap";
            4: return "partial_shift";
            5: return "close_updates";
            default: return "reset_init";
        endcase
    endfunction

    // page p shows row p, 16 digits of 8 columns, leftmost digit is bits 63..60
    function automatic logic [7:0] reference_byte(input int i);
        int         page;
        int         col;
        int         digit;
        int         pos;
        logic [3:0] nibble;
        page   = i / column_count;
        col    = i % column_count;
        digit  = col / digit_columns;
        pos    = col % digit_columns;
        nibble = model_rows[page][capture_bits - 1 - 4 * digit -: 4];
        return (pos < glyph_columns) ? hex_font[nibble][pos] : 8'h00;  // gap columns dark
    endfunction

    // pin state around reset, and no clock outside a byte
    always @(posedge clk) begin
        cycle  <= cycle + 1;
        rst_q  <= arst_n;
        rst_qq <= rst_q;
        if (!arst_n && cycle >= 2 && (oled_resn || !oled_csn || oled_clk)) begin
            pin_errors = pin_errors + 1;
            $display("ERROR: oled pins not idle during reset (resn %b csn %b clk %b)",
                     oled_resn, oled_csn, oled_clk);
        end
        if (rst_qq && !oled_resn) begin
            pin_errors = pin_errors + 1;
            $display("CHECK FAILED %s: oled_resn expected 1 actual %b",
                     step_name(test_step), oled_resn);
        end
        if (rst_qq && oled_csn && oled_clk) begin
            pin_errors = pin_errors + 1;
            $display("ERROR: oled_clk high while oled_csn is high");
        end
    end

    // model of the running tdi shift register
    always @(posedge jtck or negedge arst_n) begin
        if (!arst_n) begin
            model_shift <= '0;
        end else begin
            model_shift <= {model_shift[capture_bits-2:0], jtdi};
        end
    end

    // each update stores the register in the next row
    always @(posedge jupdate or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < row_count; i++) begin
                model_rows[i] <= '0;
            end
            model_row   <= '0;
            last_update <= -1000;
        end else begin
            model_rows[model_row] <= model_shift;
            model_row   <= model_row + 1'b1;  // wraps at row_count
            last_update <= cycle;
        end
    end

    task automatic compare_frame(input int frame_no);
        logic [7:0] expected;
        int         shown;
        shown = 0;
        for (int i = 0; i < frame_bytes; i++) begin
            expected = reference_byte(i);
            if (frame_buf[i] !== expected) begin
                value_errors = value_errors + 1;
                if (shown < 4) begin
                    $display("CHECK FAILED %s: frame %0d byte %0d expected %02h actual %02h",
                             step_name(test_step), frame_no, i, expected, frame_buf[i]);
                end
                shown = shown + 1;
            end
        end
        frames_checked = frames_checked + 1;
    endtask

    task automatic take_byte(input logic [7:0] value, input logic dc);
        int idx;
        if (init_seen < init_length) begin
            if (dc !== 1'b0 || value !== init_bytes[init_seen]) begin
                value_errors = value_errors + 1;
                $display("CHECK FAILED %s: init byte %0d expected dc 0 %02h actual dc %b %02h",
                         step_name(test_step), init_seen, init_bytes[init_seen], dc, value);
            end
            init_seen = init_seen + 1;
        end else if (dc !== 1'b1) begin
            stream_errors = stream_errors + 1;
            $display("ERROR: command byte %02h sent after the init sequence", value);
        end else begin
            idx = data_bytes % frame_bytes;
            if (idx == 0) frame_start = cycle;  // first pixel byte marks the frame
            frame_buf[idx] = value;
            data_bytes     = data_bytes + 1;
            // frames that saw an update, or follow one closely, are skipped
            if (idx == frame_bytes - 1 && last_update + settle_cycles <= frame_start) begin
                compare_frame(data_bytes / frame_bytes - 1);
            end
        end
    endtask

    // spi decode, panel side view
    always @(posedge oled_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_count      = 0;
            init_seen      = 0;
            data_bytes     = 0;
            frames_checked = 0;
            value_errors   = 0;
            stream_errors  = 0;
        end else if (!oled_csn) begin
            shift_in  = {shift_in[6:0], oled_mosi};  // msb first
            bit_count = bit_count + 1;
            if (bit_count == 8) begin
                bit_count = 0;
                take_byte(shift_in, oled_dc);
            end
        end
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // release lands on a clock edge, like every other stimulus
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- rtl/jtag_scope_top.sv
`timescale 1ns/1ps

module jtag_scope_top (
    input  logic clk,
    input  logic arst_n,
    input  logic jtck,       // from the vendor jtag passthrough
    input  logic jtdi,
    input  logic jupdate,
    output logic oled_csn,
    output logic oled_clk,
    output logic oled_mosi,
    output logic oled_dc,
    output logic oled_resn
);
    import jtag_pkg::*;

    // capture to buffer
    logic                     wr_req;
    logic [row_addr_bits-1:0] wr_row;
    logic [capture_bits-1:0]  wr_data;
    logic                     wr_ack;
    // renderer to buffer
    logic                     rd_req;
    logic [row_addr_bits-1:0] rd_row;
    logic                     rd_ack;
    logic [capture_bits-1:0]  rd_data;
    // renderer to serializer
    logic                     byte_req;
    logic [7:0]               byte_data;
    logic                     byte_dc;
    logic                     byte_ack;

    jtag_capture jtag_capture_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .jtck    (jtck),
        .jtdi    (jtdi),
        .jupdate (jupdate),
        .wr_req  (wr_req),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .wr_ack  (wr_ack)
    );

    display_buffer display_buffer_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_req  (wr_req),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .wr_ack  (wr_ack),
        .rd_req  (rd_req),
        .rd_row  (rd_row),
        .rd_ack  (rd_ack),
        .rd_data (rd_data)
    );

    hex_renderer hex_renderer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_req    (rd_req),
        .rd_row    (rd_row),
        .rd_ack    (rd_ack),
        .rd_data   (rd_data),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_dc   (byte_dc),
        .byte_ack  (byte_ack)
    );

    oled_spi oled_spi_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_dc   (byte_dc),
        .byte_ack  (byte_ack),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

endmodule

//--- rtl/oled_spi.sv
`timescale 1ns/1ps

module oled_spi (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       byte_req,
    input  logic [7:0] byte_data,
    input  logic       byte_dc,
    output logic       byte_ack,   // rises once all 8 bits are out
    output logic       oled_csn,
    output logic       oled_clk,   // clk/2 while shifting
    output logic       oled_mosi,
    output logic       oled_dc,
    output logic       oled_resn
);
    import display_pkg::*;

    spi_state_t state;
    logic [2:0] bit_cnt;   // bits already presented on mosi, minus one
    logic [7:0] shreg;
    logic       start;
    logic       fall;      // oled_clk goes low this cycle

    assign start = (state == spi_idle) && !byte_ack && byte_req;
    assign fall  = (state == spi_shift) && oled_clk;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= spi_idle;
            bit_cnt   <= '0;
            byte_ack  <= 1'b0;
            oled_csn  <= 1'b1;
            oled_clk  <= 1'b0;
            oled_mosi <= 1'b0;
            oled_dc   <= 1'b0;
            oled_resn <= 1'b0;  // panel held in reset with us
        end else begin
            oled_resn <= 1'b1;
            case (state)
                spi_idle: begin
                    if (byte_ack) begin
                        if (!byte_req) byte_ack <= 1'b0;  // phase 4
                    end else if (start) begin
                        oled_csn  <= 1'b0;
                        oled_dc   <= byte_dc;       // held through the byte
                        oled_mosi <= byte_data[7];  // msb first
                        bit_cnt   <= '0;
                        state     <= spi_shift;
                    end
                end
                spi_shift: begin
                    if (!oled_clk) begin
                        oled_clk <= 1'b1;  // panel samples here
                    end else begin
                        oled_clk <= 1'b0;
                        if (bit_cnt == 3'd7) begin
                            state <= spi_finish;
                        end else begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            oled_mosi <= shreg[6];  // next bit while clk is low
                        end
                    end
                end
                spi_finish: begin
                    oled_csn <= 1'b1;
                    byte_ack <= 1'b1;  // 18 cycles after req
                    state    <= spi_idle;
                end
                default: state <= spi_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= byte_data;
        end else if (fall && bit_cnt != 3'd7) begin
            shreg <= shreg << 1;
        end
    end

endmodule

//--- rtl/hex_renderer.sv
`timescale 1ns/1ps

module hex_renderer (
    input  logic                               clk,
    input  logic                               arst_n,
    // buffer read port
    output logic                               rd_req,
    output logic [jtag_pkg::row_addr_bits-1:0] rd_row,
    input  logic                               rd_ack,
    input  logic [jtag_pkg::capture_bits-1:0]  rd_data,
    // byte stream to the serializer
    output logic                               byte_req,
    output logic [7:0]                         byte_data,
    output logic                               byte_dc,    // 0 command, 1 pixels
    input  logic                               byte_ack
);
    import jtag_pkg::*;
    import display_pkg::*;

    render_state_t              state;
    logic [2:0]                 init_idx;    // next init byte
    logic [7:0]                 col;         // pixel bytes issued on this page
    logic [row_addr_bits-1:0]   page;
    logic [capture_bits-1:0]    row_data;
    logic [3:0]                 digit;       // hex digit under the current column
    logic [3:0]                 nibble;
    logic [2:0]                 glyph_pos;
    logic [7:0]                 pixel_byte;
    logic                       byte_free;
    logic                       send_init;
    logic                       send_pixel;
    logic                       fetch_done;

    assign rd_row = page;

    // both req and ack low means the last byte finished all four phases
    assign byte_free  = !byte_req && !byte_ack;
    assign send_init  = (state == rnd_init) && byte_free && (init_idx != 3'(init_length));
    assign send_pixel = (state == rnd_pixels) && byte_free && (col != 8'(column_count));
    assign fetch_done = (state == rnd_fetch) && rd_req && rd_ack;

    // digit c/8 from the left, leftmost digit is bits 63..60
    assign digit       = 4'(col[6:0] / digit_columns);
    assign nibble      = row_data[{~digit, 2'b00} +: 4];  // digit 15 sits at bit 0
    assign glyph_pos   = 3'(col[6:0] % digit_columns);
    assign pixel_byte  = (glyph_pos < 3'(glyph_columns)) ? hex_font[nibble][glyph_pos[1:0]]
                                                         : 8'h00;  // gap between digits

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= rnd_init;
            init_idx <= '0;
            col      <= '0;
            page     <= '0;
            rd_req   <= 1'b0;
            byte_req <= 1'b0;
            byte_dc  <= 1'b0;
        end else begin
            if (byte_req && byte_ack) byte_req <= 1'b0;  // acked, drop req
            case (state)
                rnd_init: begin
                    if (send_init) begin
                        byte_req <= 1'b1;
                        byte_dc  <= 1'b0;
                        init_idx <= init_idx + 1'b1;
                    end else if (byte_free) begin
                        state <= rnd_fetch;  // init is never sent again
                    end
                end
                rnd_fetch: begin
                    if (!rd_req && !rd_ack) begin
                        rd_req <= 1'b1;  // previous read fully released
                    end else if (fetch_done) begin
                        rd_req <= 1'b0;
                        col    <= '0;
                        state  <= rnd_pixels;
                    end
                end
                rnd_pixels: begin
                    if (send_pixel) begin
                        byte_req <= 1'b1;
                        byte_dc  <= 1'b1;
                        col      <= col + 1'b1;
                    end else if (byte_free) begin
                        // page done, wrap after the last one
                        page  <= (page == row_addr_bits'(page_count - 1)) ? '0 : page + 1'b1;
                        state <= rnd_fetch;
                    end
                end
                default: state <= rnd_init;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) row_data <= rd_data;
        if (send_init) begin
            byte_data <= init_bytes[init_idx];
        end else if (send_pixel) begin
            byte_data <= pixel_byte;
        end
    end

endmodule

//--- rtl/display_buffer.sv
`timescale 1ns/1ps

module display_buffer (
    input  logic                               clk,
    input  logic                               arst_n,
    // capture side
    input  logic                               wr_req,
    input  logic [jtag_pkg::row_addr_bits-1:0] wr_row,
    input  logic [jtag_pkg::capture_bits-1:0]  wr_data,
    output logic                               wr_ack,
    // renderer side
    input  logic                               rd_req,
    input  logic [jtag_pkg::row_addr_bits-1:0] rd_row,
    output logic                               rd_ack,
    output logic [jtag_pkg::capture_bits-1:0]  rd_data
);
    import jtag_pkg::*;

    logic [capture_bits-1:0] rows [row_count];
    logic                    wr_grant;     // capture owns the buffer
    logic                    rd_grant;     // renderer owns the buffer
    logic                    buffer_free;
    logic                    rd_start;

    assign buffer_free = !wr_grant && !rd_grant;
    assign rd_start    = buffer_free && !wr_req && rd_req;  // write wins a tie

    // acks are the grant flops, so they trail req by one cycle both ways
    assign wr_ack = wr_grant;
    assign rd_ack = rd_grant;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_grant <= 1'b0;
            rd_grant <= 1'b0;
            for (int i = 0; i < row_count; i++) begin
                rows[i] <= '0;  // blank screen shows all zero digits
            end
        end else begin
            if (wr_grant) begin
                if (!wr_req) wr_grant <= 1'b0;  // held until req drops
            end else if (rd_grant) begin
                if (!rd_req) rd_grant <= 1'b0;
            end else if (wr_req) begin
                wr_grant     <= 1'b1;
                rows[wr_row] <= wr_data;
            end else if (rd_req) begin
                rd_grant <= 1'b1;
            end
        end
    end

    // read data is latched with the grant and stays put while rd_ack is high
    always_ff @(posedge clk) begin
        if (rd_start) rd_data <= rows[rd_row];
    end

endmodule

//--- rtl/jtag_capture.sv
`timescale 1ns/1ps

module jtag_capture (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               jtck,     // tck from the passthrough primitive
    input  logic                               jtdi,
    input  logic                               jupdate,  // end of a shift, one tck wide
    output logic                               wr_req,
    output logic [jtag_pkg::row_addr_bits-1:0] wr_row,
    output logic [jtag_pkg::capture_bits-1:0]  wr_data,
    input  logic                               wr_ack
);
    import jtag_pkg::*;

    logic [sync_stages-1:0]  jtck_sync;     // top bit is the clean copy
    logic [sync_stages-1:0]  jtdi_sync;
    logic [sync_stages-1:0]  jupdate_sync;
    logic                    jtck_prev;
    logic                    jupdate_prev;
    logic                    jtck_rise;
    logic                    jupdate_rise;
    logic [capture_bits-1:0] shift_reg;
    capture_state_t          state;

    // edge detect on the synchronized copies
    assign jtck_rise    = jtck_sync[sync_stages-1] & ~jtck_prev;
    assign jupdate_rise = jupdate_sync[sync_stages-1] & ~jupdate_prev;

    assign wr_req = (state == cap_request);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            jtck_sync    <= '0;
            jtdi_sync    <= '0;
            jupdate_sync <= '0;
            jtck_prev    <= 1'b0;
            jupdate_prev <= 1'b0;
        end else begin
            jtck_sync    <= {jtck_sync[sync_stages-2:0], jtck};
            jtdi_sync    <= {jtdi_sync[sync_stages-2:0], jtdi};  // same depth keeps tdi aligned
            jupdate_sync <= {jupdate_sync[sync_stages-2:0], jupdate};
            jtck_prev    <= jtck_sync[sync_stages-1];
            jupdate_prev <= jupdate_sync[sync_stages-1];
        end
    end

    // running shift register, newest bit lands in bit 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_reg <= '0;
        end else if (jtck_rise) begin
            shift_reg <= {shift_reg[capture_bits-2:0], jtdi_sync[sync_stages-1]};
        end
    end

    // four-phase write, an update seen outside idle is lost
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= cap_idle;
            wr_row <= '0;
        end else begin
            case (state)
                cap_idle: begin
                    if (jupdate_rise) state <= cap_request;
                end
                cap_request: begin
                    if (wr_ack) state <= cap_release;  // buffer took the row
                end
                cap_release: begin
                    if (!wr_ack) begin
                        state  <= cap_idle;
                        wr_row <= wr_row + 1'b1;  // wraps after row_count rows
                    end
                end
                default: state <= cap_idle;
            endcase
        end
    end

    // snapshot taken on the same edge that leaves idle
    always_ff @(posedge clk) begin
        if (state == cap_idle && jupdate_rise) wr_data <= shift_reg;
    end

endmodule

//--- rtl/display_pkg.sv
package display_pkg;

    // panel geometry, 128x32 ssd1306
    localparam int page_count    = 4;    // eight pixel rows per page
    localparam int column_count  = 128;
    localparam int digit_columns = 8;    // glyph plus gap
    localparam int glyph_columns = 4;

    // 3x5 hex digits on pixel rows 1..5, bit 0 is the top row
    // fourth column stays dark as letter spacing
    localparam logic [7:0] hex_font [16][glyph_columns] = '{
        '{8'h3E, 8'h22, 8'h3E, 8'h00},  // 0
        '{8'h24, 8'h3E, 8'h20, 8'h00},  // 1
        '{8'h3A, 8'h2A, 8'h2E, 8'h00},  // 2
        '{8'h2A, 8'h2A, 8'h3E, 8'h00},  // 3
        '{8'h0E, 8'h08, 8'h3E, 8'h00},  // 4
        '{8'h2E, 8'h2A, 8'h3A, 8'h00},  // 5
        '{8'h3E, 8'h2A, 8'h3A, 8'h00},  // 6
        '{8'h02, 8'h02, 8'h3E, 8'h00},  // 7
        '{8'h3E, 8'h2A, 8'h3E, 8'h00},  // 8
        '{8'h2E, 8'h2A, 8'h3E, 8'h00},  // 9
        '{8'h3E, 8'h0A, 8'h3E, 8'h00},  // a
        '{8'h3E, 8'h2A, 8'h14, 8'h00},  // b
        '{8'h3E, 8'h22, 8'h22, 8'h00},  // c
        '{8'h3E, 8'h22, 8'h1C, 8'h00},  // d
        '{8'h3E, 8'h2A, 8'h2A, 8'h00},  // e
        '{8'h3E, 8'h0A, 8'h0A, 8'h00}   // f
    };

    // panel comes out of reset with the display off and columns at 0..127
    localparam int init_length = 6;
    localparam logic [7:0] init_bytes [init_length] = '{
        8'h20, 8'h00,         // horizontal addressing
        8'h22, 8'h00, 8'h03,  // pages 0..3 only
        8'hAF                 // display on
    };

    typedef enum logic [1:0] {
        rnd_init,    // command bytes, once after reset
        rnd_fetch,   // read one row from the buffer
        rnd_pixels   // 128 column bytes of the current page
    } render_state_t;

    typedef enum logic [1:0] {
        spi_idle,
        spi_shift,
        spi_finish
    } spi_state_t;

endpackage

//--- rtl/jtag_pkg.sv
package jtag_pkg;

    // capture side geometry
    localparam int capture_bits  = 64;  // shift register and row width
    localparam int row_count     = 4;   // one row per oled page
    localparam int row_addr_bits = 2;
    localparam int sync_stages   = 2;   // flops in front of every jtag input

    // write handshake toward the display buffer
    typedef enum logic [1:0] {
        cap_idle,     // waiting for a jupdate edge
        cap_request,  // wr_req high, data held
        cap_release   // wr_req low, waiting for wr_ack to fall
    } capture_state_t;

endpackage
